// ==== all.f ====
rtl/tlk_rx_pkg.sv
rtl/rx_dma_pkg.sv
rtl/rx_frame_if.sv
rtl/rx_frame_parser.sv
rtl/rx_beat_packer.sv
rtl/rx_wr_cmd_gen.sv
rtl/tlk2711_rx_link.sv
tb/rx_link_assertions.sv
tb/tb_tlk2711_rx_link.sv

// ==== rtl/rx_beat_packer.sv ====
////////////////////////////////////////////////////////////////////////////
// Payload beat packer
// Packs four words per 64-bit beat and queues beats for the DMA stream
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rx_beat_packer (
    input  logic              clk,
    input  logic              i_rst,
    input  logic              i_dma_wr_ready,
    rx_frame_if.packer        frm,
    output logic              o_dma_wr_valid,
    output rx_dma_pkg::beat_t o_dma_wr_data,
    output logic              o_fifo_overflow,
    output logic              o_fifo_empty,
    output logic              o_fifo_full
);
    import rx_dma_pkg::*;

    logic [$clog2(WORDS_PER_BEAT)-1:0] lane;
    beat_t                             beat_q;
    beat_t                             beat_nxt;
    logic                              flush;
    logic                              pop;
    beat_t                             fifo_mem [FIFO_DEPTH];
    logic [FIFO_PTR_W:0]               wr_ptr;
    logic [FIFO_PTR_W:0]               rd_ptr;

    ////////////////////////////////////////////////////////////////////////
    // Packing, word k goes to lane k from the low end
    ////////////////////////////////////////////////////////////////////////
    always_comb begin
        // A fresh beat starts from zero so short frames come out padded
        beat_nxt = (lane == '0) ? '0 : beat_q;
        beat_nxt[lane * (BEAT_W / WORDS_PER_BEAT) +: (BEAT_W / WORDS_PER_BEAT)] = frm.word;
    end

    assign flush = frm.word_valid && ((&lane) || frm.last_word);

    always_ff @(posedge clk) begin
        if (i_rst)
            lane <= '0;
        else if (frm.word_valid)
            lane <= flush ? '0 : lane + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (frm.word_valid)
            beat_q <= beat_nxt;
    end

    ////////////////////////////////////////////////////////////////////////
    // First-word-fall-through beat FIFO
    ////////////////////////////////////////////////////////////////////////
    assign o_fifo_empty   = (wr_ptr == rd_ptr);
    assign o_fifo_full    = (wr_ptr[FIFO_PTR_W] != rd_ptr[FIFO_PTR_W]) &&
                            (wr_ptr[FIFO_PTR_W-1:0] == rd_ptr[FIFO_PTR_W-1:0]);
    assign o_dma_wr_valid = !o_fifo_empty;
    assign o_dma_wr_data  = fifo_mem[rd_ptr[FIFO_PTR_W-1:0]];
    assign pop            = o_dma_wr_valid && i_dma_wr_ready;

    always_ff @(posedge clk) begin
        if (flush && !o_fifo_full)
            fifo_mem[wr_ptr[FIFO_PTR_W-1:0]] <= beat_nxt;
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr          <= '0;
            rd_ptr          <= '0;
            o_fifo_overflow <= 1'b0;
        end else begin
            if (flush && !o_fifo_full)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            // Beat dropped on a full FIFO, flag stays until reset
            if (flush && o_fifo_full)
                o_fifo_overflow <= 1'b1;
        end
    end

endmodule

// ==== rtl/rx_dma_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// DMA side definitions
// Write address, byte count, beat types and beat FIFO depth
////////////////////////////////////////////////////////////////////////////

package rx_dma_pkg;

    localparam int ADDR_W         = 32;
    localparam int BEAT_W         = 64;
    localparam int WORDS_PER_BEAT = 4;

    // Beat FIFO, depth in beats
    localparam int FIFO_DEPTH     = 32;
    localparam int FIFO_PTR_W     = $clog2(FIFO_DEPTH);

    typedef logic [ADDR_W-1:0]   addr_t;
    // Byte count rounded up to whole beats
    typedef logic [15:0]         byte_cnt_t;
    typedef logic [BEAT_W-1:0]   beat_t;
    typedef logic [BEAT_W/8-1:0] keep_t;

endpackage

// ==== rtl/rx_frame_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Frame interface from the parser
// Payload words for the packer, header length for the command block
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface rx_frame_if;
    import tlk_rx_pkg::*;

    // Payload stream, no back-pressure
    logic       word_valid;
    rx_word_t   word;
    logic       last_word;

    // Header length, held from the pulse until the next frame
    logic       hdr_valid;
    frame_len_t byte_len;

    modport parser (
        output word_valid, word, last_word, hdr_valid, byte_len
    );

    modport packer (
        input  word_valid, word, last_word
    );

    modport cmd (
        input  hdr_valid, byte_len
    );

endinterface

// ==== rtl/rx_frame_parser.sv ====
////////////////////////////////////////////////////////////////////////////
// TLK2711 receive frame parser
// Locks on sync and start of frame, captures the header, checks the sum
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rx_frame_parser (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_rkmsb,
    input  logic                   i_rklsb,
    input  tlk_rx_pkg::rx_word_t   i_rxd,
    rx_frame_if.parser             frm,
    output tlk_rx_pkg::line_num_t  o_line_num,
    output tlk_rx_pkg::frame_len_t o_frame_len,
    output tlk_rx_pkg::data_type_t o_data_type,
    output tlk_rx_pkg::chan_id_t   o_channel_id,
    output logic                   o_file_end,
    output logic                   o_checksum_err,
    output tlk_rx_pkg::rx_state_t  o_state
);
    import tlk_rx_pkg::*;

    rx_state_t   state;
    rx_state_t   state_nxt;
    rx_word_t    prev_word;
    rx_word_t    type_word;
    rx_word_t    line_word;
    frame_len_t  len_q;
    rx_word_t    checksum;
    logic [14:0] word_cnt;
    logic        data_last;

    // Payload is length/2 words, length is at least 2
    assign data_last    = (word_cnt == len_q[15:1] - 15'd1);
    assign frm.byte_len = len_q;
    assign o_state      = state;

    ////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (!i_rkmsb && i_rklsb && i_rxd == SYNC_WORD)
                    state_nxt = SYNC;
            end
            SYNC: begin
                // Idle words keep the lock, anything else drops it
                if (i_rkmsb && i_rklsb && i_rxd == SOF_WORD)
                    state_nxt = HEAD;
                else if (!(!i_rkmsb && i_rklsb && i_rxd == SYNC_WORD))
                    state_nxt = IDLE;
            end
            HEAD: begin
                if (prev_word == HEAD_FLAG_HI && i_rxd == HEAD_FLAG_LO)
                    state_nxt = TYPE;
            end
            TYPE:   state_nxt = LINE;
            LINE:   state_nxt = LENGTH;
            LENGTH: state_nxt = DATA;
            DATA: begin
                if (data_last)
                    state_nxt = CHECK;
            end
            CHECK:  state_nxt = END1;
            // Frame end K codes are not checked
            END1:   state_nxt = END2;
            END2:   state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////
    // Control and frame interface strobes
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_rst) begin
            state          <= IDLE;
            word_cnt       <= '0;
            frm.word_valid <= 1'b0;
            frm.last_word  <= 1'b0;
            frm.hdr_valid  <= 1'b0;
        end else begin
            state          <= state_nxt;
            word_cnt       <= (state == DATA) ? word_cnt + 15'd1 : '0;
            frm.word_valid <= (state == DATA);
            frm.last_word  <= (state == DATA) && data_last;
            frm.hdr_valid  <= (state == LENGTH);
        end
    end

    // Word history, header words and running checksum
    always_ff @(posedge clk) begin
        prev_word <= i_rxd;
        frm.word  <= i_rxd;
        if (state == TYPE)
            type_word <= i_rxd;
        if (state == LINE)
            line_word <= i_rxd;
        if (state == LENGTH)
            len_q <= i_rxd;
        if (state inside {TYPE, LINE, LENGTH, DATA})
            checksum <= checksum + i_rxd;
        else
            checksum <= '0;
    end

    // Header fields published together with the checksum result
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_line_num     <= '0;
            o_frame_len    <= '0;
            o_data_type    <= '0;
            o_channel_id   <= '0;
            o_file_end     <= 1'b0;
            o_checksum_err <= 1'b0;
        end else if (state == CHECK) begin
            // Type word: file_end[15:14], channel[13:12], type[11:8], line hi
            o_file_end     <= type_word[14];
            o_channel_id   <= type_word[13:12];
            o_data_type    <= type_word[11:8];
            o_line_num     <= {type_word[7:0], line_word};
            o_frame_len    <= len_q;
            o_checksum_err <= (checksum != i_rxd);
        end
    end

endmodule

// ==== rtl/rx_wr_cmd_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// DMA write command generator
// Tracks the write address and requests one command per frame
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rx_wr_cmd_gen (
    input  logic                  clk,
    input  logic                  i_rst,
    input  logic                  i_rx_start,
    input  rx_dma_pkg::addr_t     i_rx_base_addr,
    input  logic                  i_wr_cmd_ack,
    rx_frame_if.cmd               frm,
    output logic                  o_wr_cmd_req,
    output rx_dma_pkg::addr_t     o_wr_cmd_addr,
    output rx_dma_pkg::byte_cnt_t o_wr_cmd_len
);
    import rx_dma_pkg::*;

    // Four-phase request handshake
    typedef enum logic [1:0] {IDLE, REQ, WAIT_LOW} cmd_state_t;

    cmd_state_t state;
    byte_cnt_t  hdr_cnt;
    byte_cnt_t  pend_cnt;
    byte_cnt_t  cmd_cnt;
    addr_t      wr_addr;
    addr_t      cur_addr;
    logic       pend;
    logic       launch;

    // Length rounded up to whole 8-byte beats
    assign hdr_cnt  = {frm.byte_len[15:3] + 13'(|frm.byte_len[2:0]), 3'b000};

    // The pending command goes first, a new header waits behind it
    assign launch   = (state == IDLE) && (pend || frm.hdr_valid);
    assign cmd_cnt  = pend ? pend_cnt : hdr_cnt;
    assign cur_addr = i_rx_start ? i_rx_base_addr : wr_addr;

    assign o_wr_cmd_req = (state == REQ);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state   <= IDLE;
            pend    <= 1'b0;
            wr_addr <= '0;
        end else begin
            case (state)
                IDLE:     if (launch) state <= REQ;
                REQ:      if (i_wr_cmd_ack) state <= WAIT_LOW;
                WAIT_LOW: if (!i_wr_cmd_ack) state <= IDLE;
                default:  state <= IDLE;
            endcase

            if (launch)
                pend <= pend && frm.hdr_valid;
            else if (frm.hdr_valid)
                pend <= 1'b1;

            if (launch)
                wr_addr <= cur_addr + addr_t'(cmd_cnt);
            else if (i_rx_start)
                wr_addr <= i_rx_base_addr;
        end
    end

    // Command fields, stable for the whole request
    always_ff @(posedge clk) begin
        if (frm.hdr_valid)
            pend_cnt <= hdr_cnt;
        if (launch) begin
            o_wr_cmd_addr <= cur_addr;
            o_wr_cmd_len  <= cmd_cnt;
        end
    end

endmodule

// ==== rtl/tlk2711_rx_link.sv ====
////////////////////////////////////////////////////////////////////////////
// TLK2711 receive link top level
// Frame parser, beat packer and DMA write command generator
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tlk2711_rx_link (
    input  logic                   clk,
    input  logic                   i_rst,

    // Serdes receive side
    input  logic                   i_2711_rkmsb,
    input  logic                   i_2711_rklsb,
    input  tlk_rx_pkg::rx_word_t   i_2711_rxd,

    // DMA write command, four-phase req/ack
    input  logic                   i_rx_start,
    input  rx_dma_pkg::addr_t      i_rx_base_addr,
    input  logic                   i_wr_cmd_ack,
    output logic                   o_wr_cmd_req,
    output rx_dma_pkg::addr_t      o_wr_cmd_addr,
    output rx_dma_pkg::byte_cnt_t  o_wr_cmd_len,

    // DMA write stream
    input  logic                   i_dma_wr_ready,
    output logic                   o_dma_wr_valid,
    output rx_dma_pkg::beat_t      o_dma_wr_data,
    output rx_dma_pkg::keep_t      o_dma_wr_keep,

    // Frame header and status
    output logic                   o_hdr_valid,
    output tlk_rx_pkg::line_num_t  o_line_num,
    output tlk_rx_pkg::frame_len_t o_frame_len,
    output tlk_rx_pkg::data_type_t o_data_type,
    output tlk_rx_pkg::chan_id_t   o_channel_id,
    output logic                   o_file_end,
    output logic                   o_rx_checksum_err,
    output logic                   o_fifo_overflow,
    output logic [5:0]             o_rx_status
);
    import tlk_rx_pkg::*;

    rx_frame_if frm ();

    rx_state_t rx_state;
    logic      fifo_empty;
    logic      fifo_full;

    assign o_hdr_valid   = frm.hdr_valid;
    assign o_dma_wr_keep = '1;
    assign o_rx_status   = {fifo_empty, fifo_full, rx_state};

    rx_frame_parser rx_frame_parser_inst (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_rkmsb        (i_2711_rkmsb),
        .i_rklsb        (i_2711_rklsb),
        .i_rxd          (i_2711_rxd),
        .frm            (frm.parser),
        .o_line_num     (o_line_num),
        .o_frame_len    (o_frame_len),
        .o_data_type    (o_data_type),
        .o_channel_id   (o_channel_id),
        .o_file_end     (o_file_end),
        .o_checksum_err (o_rx_checksum_err),
        .o_state        (rx_state)
    );

    rx_beat_packer rx_beat_packer_inst (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_dma_wr_ready  (i_dma_wr_ready),
        .frm             (frm.packer),
        .o_dma_wr_valid  (o_dma_wr_valid),
        .o_dma_wr_data   (o_dma_wr_data),
        .o_fifo_overflow (o_fifo_overflow),
        .o_fifo_empty    (fifo_empty),
        .o_fifo_full     (fifo_full)
    );

    rx_wr_cmd_gen rx_wr_cmd_gen_inst (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_rx_start     (i_rx_start),
        .i_rx_base_addr (i_rx_base_addr),
        .i_wr_cmd_ack   (i_wr_cmd_ack),
        .frm            (frm.cmd),
        .o_wr_cmd_req   (o_wr_cmd_req),
        .o_wr_cmd_addr  (o_wr_cmd_addr),
        .o_wr_cmd_len   (o_wr_cmd_len)
    );

endmodule

// ==== rtl/tlk_rx_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// TLK2711 receive link definitions
// K-code words, header flag, frame field types and parser states
////////////////////////////////////////////////////////////////////////////

package tlk_rx_pkg;

    // Idle word {D5.6, K28.5}, K flag on the low byte only
    localparam logic [15:0] SYNC_WORD    = 16'hC5BC;

    // Start of frame {K28.2, K27.7}, both bytes are K characters
    localparam logic [15:0] SOF_WORD     = 16'h5CFB;

    // Two-word frame header flag
    localparam logic [15:0] HEAD_FLAG_HI = 16'hEB90;
    localparam logic [15:0] HEAD_FLAG_LO = 16'hE116;

    typedef logic [15:0] rx_word_t;
    typedef logic [23:0] line_num_t;
    // Frame length in bytes
    typedef logic [15:0] frame_len_t;
    typedef logic [3:0]  data_type_t;
    typedef logic [1:0]  chan_id_t;

    // Frame parser states, one serdes word consumed per state per cycle
    typedef enum logic [3:0] {
        IDLE   = 4'd0,
        SYNC   = 4'd1,
        HEAD   = 4'd2,
        TYPE   = 4'd3,
        LINE   = 4'd4,
        LENGTH = 4'd5,
        DATA   = 4'd6,
        CHECK  = 4'd7,
        END1   = 4'd8,
        END2   = 4'd9
    } rx_state_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the TLK2711 receive link testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f all.f --top-module tb_tlk2711_rx_link -Mdir obj_dir \
    && ./obj_dir/Vtb_tlk2711_rx_link > sim.log 2>&1 \
    || { echo "Build or simulation failed, see sim.log"; exit 1; }

grep -q "=== PASS ===" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== tb/rx_link_assertions.sv ====
////////////////////////////////////////////////////////////////////////////
// Handshake assertions for the TLK2711 receive link
// Bound to the top level, checks the command and DMA stream handshakes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rx_link_assertions (
    input logic                  clk,
    input logic                  i_rst,
    input logic                  i_wr_cmd_ack,
    input logic                  o_wr_cmd_req,
    input rx_dma_pkg::addr_t     o_wr_cmd_addr,
    input rx_dma_pkg::byte_cnt_t o_wr_cmd_len,
    input logic                  i_dma_wr_ready,
    input logic                  o_dma_wr_valid,
    input rx_dma_pkg::beat_t     o_dma_wr_data
);

    // Request stays up until the ack is seen
    req_until_ack: assert property (@(posedge clk) disable iff (i_rst)
        o_wr_cmd_req && !i_wr_cmd_ack |=> o_wr_cmd_req)
        else $error("write command request dropped before ack");

    // A new request only after ack has returned low
    req_after_ack_low: assert property (@(posedge clk) disable iff (i_rst)
        $rose(o_wr_cmd_req) |-> $past(!i_wr_cmd_ack))
        else $error("write command request raised while ack was high");

    cmd_fields_stable: assert property (@(posedge clk) disable iff (i_rst)
        o_wr_cmd_req && !i_wr_cmd_ack |=> $stable(o_wr_cmd_addr) && $stable(o_wr_cmd_len))
        else $error("write command fields changed during the request");

    // A stalled beat stays at the FIFO head
    beat_held_on_stall: assert property (@(posedge clk) disable iff (i_rst)
        o_dma_wr_valid && !i_dma_wr_ready |=> o_dma_wr_valid && $stable(o_dma_wr_data))
        else $error("DMA beat changed while the sink stalled");

endmodule

// ==== tb/tb_tlk2711_rx_link.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the TLK2711 receive link
// Random frames checked against a model of beats, commands and headers
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_tlk2711_rx_link;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_FRAMES = 40;
    // Longest frame with its prelude in words, and longest idle stretch
    localparam int MAX_WORDS  = 44;
    localparam int MAX_GAP    = 16;
    localparam int TIMEOUT_NS = (NUM_FRAMES * (MAX_WORDS + MAX_GAP + 40) + 20) * CLK_PERIOD;

    localparam logic [15:0] SYNC_W    = 16'hC5BC;
    localparam logic [15:0] SOF_W     = 16'h5CFB;
    localparam logic [15:0] FLAG_HI_W = 16'hEB90;
    localparam logic [15:0] FLAG_LO_W = 16'hE116;
    // K29.7 pair used as the frame end code
    localparam logic [15:0] EOF_W     = 16'hFDFD;

    logic        clk;
    logic        i_rst;
    logic        i_2711_rkmsb;
    logic        i_2711_rklsb;
    logic [15:0] i_2711_rxd;
    logic        i_rx_start;
    logic [31:0] i_rx_base_addr;
    logic        i_wr_cmd_ack;
    logic        o_wr_cmd_req;
    logic [31:0] o_wr_cmd_addr;
    logic [15:0] o_wr_cmd_len;
    logic        i_dma_wr_ready;
    logic        o_dma_wr_valid;
    logic [63:0] o_dma_wr_data;
    logic [7:0]  o_dma_wr_keep;
    logic        o_hdr_valid;
    logic [23:0] o_line_num;
    logic [15:0] o_frame_len;
    logic [3:0]  o_data_type;
    logic [1:0]  o_channel_id;
    logic        o_file_end;
    logic        o_rx_checksum_err;
    logic        o_fifo_overflow;
    logic [5:0]  o_rx_status;

    logic [15:0] lfsr;
    logic [63:0] exp_beats [$];
    logic [31:0] exp_cmd_addr [$];
    logic [15:0] exp_cmd_len [$];
    logic [31:0] model_addr;
    logic        start_pend;
    logic [31:0] start_base;
    logic        req_q;
    int          ack_wait;
    int          err_cnt;
    int          beat_cnt;
    int          cmd_cnt;

    tlk2711_rx_link tlk2711_rx_link_inst (.*);

    bind tlk2711_rx_link rx_link_assertions rx_link_assertions_inst (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_wr_cmd_ack   (i_wr_cmd_ack),
        .o_wr_cmd_req   (o_wr_cmd_req),
        .o_wr_cmd_addr  (o_wr_cmd_addr),
        .o_wr_cmd_len   (o_wr_cmd_len),
        .i_dma_wr_ready (i_dma_wr_ready),
        .o_dma_wr_valid (o_dma_wr_valid),
        .o_dma_wr_data  (o_dma_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp_val,
                               input logic [63:0] got_val);
        assert (got_val === exp_val) else begin
            err_cnt++;
            $display("ERROR at %0t ns: %s expected %0h actual %0h", $time, name, exp_val, got_val);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // One serdes word per cycle, with ready stalls and the ack responder
    ////////////////////////////////////////////////////////////////////////
    task automatic drive_cycle(input logic k_msb, input logic k_lsb, input logic [15:0] word);
        @(posedge clk);
        #1;
        i_2711_rkmsb   = k_msb;
        i_2711_rklsb   = k_lsb;
        i_2711_rxd     = word;
        i_rx_start     = start_pend;
        i_rx_base_addr = start_base;
        start_pend     = 1'b0;
        // Sink stalls about one cycle in four
        i_dma_wr_ready = (take_bits(2) != 0);
        if (o_wr_cmd_req && !i_wr_cmd_ack) begin
            if (ack_wait == 0)
                i_wr_cmd_ack = 1'b1;
            else
                ack_wait--;
        end else if (!o_wr_cmd_req && i_wr_cmd_ack) begin
            i_wr_cmd_ack = 1'b0;
            ack_wait     = int'(take_bits(2));
        end
    endtask

    task automatic send_gap();
        int n;
        n = int'(take_bits(3)) + 1;
        repeat (n) drive_cycle(1'b0, 1'b1, SYNC_W);
    endtask

    // Junk ahead of a frame that must not start one
    task automatic send_prelude();
        logic [1:0] kind;
        kind = 2'(take_bits(2));
        case (kind)
            // Start of frame without the high K flag
            2'd0: drive_cycle(1'b0, 1'b1, SOF_W);
            2'd1: begin
                drive_cycle(1'b1, 1'b1, SOF_W);
                drive_cycle(1'b0, 1'b0, FLAG_HI_W);
                drive_cycle(1'b0, 1'b0, FLAG_LO_W ^ (16'h0001 << take_bits(4)));
            end
            2'd2: drive_cycle(1'b0, 1'b0, 16'(take_bits(16)));
            default: ;
        endcase
        if (kind != 2'd3)
            send_gap();
    endtask

    task automatic send_frame();
        logic [15:0] payload [$];
        logic [15:0] len;
        logic [15:0] type_w;
        logic [15:0] line_w;
        logic [15:0] sum;
        logic [15:0] cnt;
        logic [63:0] beat;
        logic [23:0] line_num;
        logic [3:0]  dtype;
        logic [1:0]  chan;
        logic [1:0]  fend;
        logic        corrupt;
        int          nwords;

        nwords   = int'(take_bits(5)) + 1;
        len      = 16'(nwords * 2);
        fend     = 2'(take_bits(2));
        chan     = 2'(take_bits(2));
        dtype    = 4'(take_bits(4));
        line_num = 24'(take_bits(24));
        corrupt  = (take_bits(2) == 0);
        type_w   = {fend, chan, dtype, line_num[23:16]};
        line_w   = line_num[15:0];
        sum      = type_w + line_w + len;
        beat     = '0;
        for (int i = 0; i < nwords; i++) begin
            payload.push_back(16'(take_bits(16)));
            sum = sum + payload[i];
            // Word i in lane i mod 4, the last beat of a frame is zero padded
            beat[16 * (i % 4) +: 16] = payload[i];
            if (i % 4 == 3 || i == nwords - 1) begin
                exp_beats.push_back(beat);
                beat = '0;
            end
        end
        cnt = (len + 16'd7) & ~16'd7;
        exp_cmd_addr.push_back(model_addr);
        exp_cmd_len.push_back(cnt);
        model_addr = model_addr + 32'(cnt);

        drive_cycle(1'b1, 1'b1, SOF_W);
        drive_cycle(1'b0, 1'b0, FLAG_HI_W);
        drive_cycle(1'b0, 1'b0, FLAG_LO_W);
        drive_cycle(1'b0, 1'b0, type_w);
        drive_cycle(1'b0, 1'b0, line_w);
        drive_cycle(1'b0, 1'b0, len);
        foreach (payload[i]) begin
            drive_cycle(1'b0, 1'b0, payload[i]);
            // Header pulse only in the cycle after the length word
            check_value("o_hdr_valid", (i == 0) ? 64'd1 : 64'd0, 64'(o_hdr_valid));
        end
        drive_cycle(1'b0, 1'b0, corrupt ? ~sum : sum);
        // Parser in CHECK while the checksum word is on the input
        check_value("o_rx_status[3:0]", 64'd7, 64'(o_rx_status[3:0]));
        drive_cycle(1'b1, 1'b1, EOF_W);
        drive_cycle(1'b1, 1'b1, EOF_W);

        // Header outputs updated one cycle after the checksum word
        check_value("o_line_num", 64'(line_num), 64'(o_line_num));
        check_value("o_frame_len", 64'(len), 64'(o_frame_len));
        check_value("o_data_type", 64'(dtype), 64'(o_data_type));
        check_value("o_channel_id", 64'(chan), 64'(o_channel_id));
        check_value("o_file_end", 64'(fend[0]), 64'(o_file_end));
        check_value("o_rx_checksum_err", 64'(corrupt), 64'(o_rx_checksum_err));
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Monitors, sampled mid-cycle
    ////////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (!i_rst && o_dma_wr_valid && i_dma_wr_ready) begin
            assert (exp_beats.size() != 0) else begin
                err_cnt++;
                $display("ERROR at %0t ns: DMA beat %h sent with no beat expected",
                         $time, o_dma_wr_data);
            end
            if (exp_beats.size() != 0)
                check_value("o_dma_wr_data", exp_beats.pop_front(), o_dma_wr_data);
            beat_cnt++;
        end
    end

    always @(negedge clk) begin
        if (!i_rst && o_wr_cmd_req && !req_q) begin
            assert (exp_cmd_len.size() != 0) else begin
                err_cnt++;
                $display("ERROR at %0t ns: write command issued with none expected", $time);
            end
            if (exp_cmd_len.size() != 0) begin
                check_value("o_wr_cmd_addr", 64'(exp_cmd_addr.pop_front()), 64'(o_wr_cmd_addr));
                check_value("o_wr_cmd_len", 64'(exp_cmd_len.pop_front()), 64'(o_wr_cmd_len));
            end
            cmd_cnt++;
        end
        req_q = o_wr_cmd_req;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        i_rst          = 1'b1;
        i_2711_rkmsb   = 1'b0;
        i_2711_rklsb   = 1'b0;
        i_2711_rxd     = '0;
        i_rx_start     = 1'b0;
        i_rx_base_addr = '0;
        i_wr_cmd_ack   = 1'b0;
        i_dma_wr_ready = 1'b0;
        lfsr           = 16'd53;
        model_addr     = '0;
        start_pend     = 1'b0;
        start_base     = '0;
        req_q          = 1'b0;
        ack_wait       = 0;
        err_cnt        = 0;
        beat_cnt       = 0;
        cmd_cnt        = 0;
        repeat (4) @(posedge clk);
        #1;
        i_rst = 1'b0;
        check_value("o_wr_cmd_req", 64'd0, 64'(o_wr_cmd_req));
        check_value("o_dma_wr_valid", 64'd0, 64'(o_dma_wr_valid));
        check_value("o_rx_checksum_err", 64'd0, 64'(o_rx_checksum_err));
        check_value("o_fifo_overflow", 64'd0, 64'(o_fifo_overflow));
        check_value("o_hdr_valid", 64'd0, 64'(o_hdr_valid));

        for (int f = 0; f < NUM_FRAMES; f++) begin
            // New base address once every earlier command has gone out
            if (f == 0 || take_bits(3) == 0) begin
                while (exp_cmd_len.size() != 0)
                    drive_cycle(1'b0, 1'b1, SYNC_W);
                start_base = {29'(take_bits(29)), 3'b000};
                start_pend = 1'b1;
                model_addr = start_base;
                drive_cycle(1'b0, 1'b1, SYNC_W);
            end
            send_gap();
            send_prelude();
            send_frame();
        end
        while (exp_beats.size() != 0 || exp_cmd_len.size() != 0)
            drive_cycle(1'b0, 1'b1, SYNC_W);
        repeat (8) drive_cycle(1'b0, 1'b1, SYNC_W);

        check_value("o_fifo_overflow", 64'd0, 64'(o_fifo_overflow));
        check_value("o_dma_wr_keep", 64'hFF, 64'(o_dma_wr_keep));
        // Beat FIFO drained and not full, parser locked on idle words
        check_value("o_rx_status", 64'({1'b1, 1'b0, 4'd1}), 64'(o_rx_status));
        $display("Errors: %0d, frames: %0d, beats: %0d, commands: %0d",
                 err_cnt, NUM_FRAMES, beat_cnt, cmd_cnt);
        if (err_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule
